// ==== src/dac_pkg.sv ====
package dac_pkg;

	// sample and batch geometry.
	localparam int sample_width  = 16;
	localparam int batch_samples = 4;
	localparam int batch_width   = sample_width * batch_samples;

	// register file seen through fresh_bits and read_resps.
	localparam int mem_size   = 16;
	localparam int word_width = 32;

	localparam int seed_valid_id = 0; // starts random mode.
	localparam int tri_wave_id   = 1; // starts triangle mode.
	localparam int pwl_prep_id   = 2; // starts segment loading.
	localparam int run_pwl_id    = 3; // starts pwl playback.
	localparam int seed_base_id  = 4; // four seeds in slots 4 to 7.

	localparam logic [sample_width-1:0] lfsr_taps = 16'hB400;

	// triangle wave, one period is 2 * tri_peak / tri_step samples.
	localparam int tri_step = 64;
	localparam int tri_peak = 4096;

	// segment word is {start[31:16], slope[15:8], length[7:0]}.
	localparam int pwl_depth       = 16;
	localparam int pwl_word_width  = 32;
	localparam int pwl_addr_width  = $clog2(pwl_depth);
	localparam int pwl_count_width = $clog2(pwl_depth + 1);

	localparam logic [1:0] mode_none = 2'd0;
	localparam logic [1:0] mode_rand = 2'd1;
	localparam logic [1:0] mode_tri  = 2'd2;
	localparam logic [1:0] mode_pwl  = 2'd3;

endpackage

// ==== src/dac_mode_decode.sv ====
`timescale 1ns/1ps

module dac_mode_decode (
	input  logic clk,
	input  logic rst,
	input  logic [dac_pkg::mem_size-1:0] fresh_bits,
	input  logic [dac_pkg::mem_size-1:0][dac_pkg::word_width-1:0] read_resps,
	input  logic halt,
	input  logic pwl_valid,
	input  logic pwl_last,
	output logic [1:0] mode,
	output logic seed_load,
	output logic [dac_pkg::batch_width-1:0] seeds,
	output logic tri_restart,
	output logic pwl_clear,
	output logic pwl_wr
);

	enum logic [1:0] {st_idle, st_seed, st_stream} state;

	logic accept;
	logic fresh_seed;
	logic fresh_tri;
	logic fresh_prep;
	logic fresh_run;

	assign fresh_seed = fresh_bits[dac_pkg::seed_valid_id];
	assign fresh_tri  = fresh_bits[dac_pkg::tri_wave_id];
	assign fresh_prep = fresh_bits[dac_pkg::pwl_prep_id];
	assign fresh_run  = fresh_bits[dac_pkg::run_pwl_id];

	// commands are only taken while idle and not halted.
	assign accept = (state == st_idle) && !halt;

	assign tri_restart = accept && !fresh_seed && fresh_tri;
	assign pwl_clear   = accept && !fresh_seed && !fresh_tri && (fresh_prep || fresh_run);
	assign seed_load   = (state == st_seed); // lfsrs pick up the captured seeds.
	assign pwl_wr      = (state == st_stream) && pwl_valid && !halt;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			mode  <= dac_pkg::mode_none;
		end else begin
			case (state)
				st_idle: begin
					if (halt) begin
						mode <= dac_pkg::mode_none;
					end else if (fresh_seed) begin
						mode  <= dac_pkg::mode_none; // old generator stops first.
						state <= st_seed;
					end else if (fresh_tri) begin
						mode <= dac_pkg::mode_tri;
					end else if (fresh_prep) begin
						mode  <= dac_pkg::mode_none;
						state <= st_stream;
					end else if (fresh_run) begin
						mode <= dac_pkg::mode_pwl;
					end
				end
				st_seed: begin
					mode  <= halt ? dac_pkg::mode_none : dac_pkg::mode_rand;
					state <= st_idle;
				end
				st_stream: begin
					if (halt) begin
						mode  <= dac_pkg::mode_none;
						state <= st_idle;
					end else if (pwl_valid && pwl_last) begin
						mode  <= dac_pkg::mode_pwl; // last word is stored at this edge.
						state <= st_idle;
					end
				end
				default: begin
					mode  <= dac_pkg::mode_none;
					state <= st_idle;
				end
			endcase
		end
	end

	// seed capture, the low half of each seed slot.
	always_ff @(posedge clk) begin
		if (accept && fresh_seed) begin
			for (int i = 0; i < dac_pkg::batch_samples; i++) begin
				seeds[i*dac_pkg::sample_width +: dac_pkg::sample_width] <=
					read_resps[dac_pkg::seed_base_id + i][dac_pkg::sample_width-1:0];
			end
		end
	end

	// register writes arrive as single-cycle pulses.
	a_fresh_pulse: assert property (@(posedge clk) disable iff (rst)
		(fresh_bits != '0) |=> (fresh_bits == '0));

endmodule

// ==== src/lfsr_bank.sv ====
`timescale 1ns/1ps

module lfsr_bank (
	input  logic clk,
	input  logic rst,
	input  logic seed_load,
	input  logic [dac_pkg::batch_width-1:0] seeds,
	input  logic step,
	output logic [dac_pkg::batch_width-1:0] batch
);

	for (genvar i = 0; i < dac_pkg::batch_samples; i++) begin : g_lfsr
		logic [dac_pkg::sample_width-1:0] state;
		logic [dac_pkg::sample_width-1:0] state_next;

		// galois form, shift right and fold the taps in on a one.
		assign state_next = state[0] ? ((state >> 1) ^ dac_pkg::lfsr_taps) : (state >> 1);

		always_ff @(posedge clk) begin
			if (rst) begin
				state <= '0;
			end else if (seed_load) begin
				state <= seeds[i*dac_pkg::sample_width +: dac_pkg::sample_width];
			end else if (step) begin
				state <= state_next;
			end
		end

		assign batch[i*dac_pkg::sample_width +: dac_pkg::sample_width] = state; // sample 0 low.
	end

endmodule

// ==== src/tri_wave_gen.sv ====
`timescale 1ns/1ps

module tri_wave_gen (
	input  logic clk,
	input  logic rst,
	input  logic restart,
	input  logic step,
	output logic [dac_pkg::batch_width-1:0] batch
);

	logic [dac_pkg::sample_width-1:0] n; // index of sample 0.

	always_ff @(posedge clk) begin
		if (rst || restart) begin
			n <= '0;
		end else if (step) begin
			n <= n + dac_pkg::sample_width'(dac_pkg::batch_samples);
		end
	end

	// n wraps at 2**16, a whole number of periods, so the fold stays continuous.
	always_comb begin
		logic [31:0] phase;
		logic [31:0] value;
		for (int i = 0; i < dac_pkg::batch_samples; i++) begin
			phase = ((32'(n) + 32'(i)) * 32'(dac_pkg::tri_step)) % 32'(2 * dac_pkg::tri_peak);
			if (phase > 32'(dac_pkg::tri_peak)) begin
				value = 32'(2 * dac_pkg::tri_peak) - phase; // falling half.
			end else begin
				value = phase;
			end
			batch[i*dac_pkg::sample_width +: dac_pkg::sample_width] =
				value[dac_pkg::sample_width-1:0];
		end
	end

endmodule

// ==== src/pwl_gen.sv ====
`timescale 1ns/1ps

module pwl_gen (
	input  logic clk,
	input  logic rst,
	input  logic clear,
	input  logic wr,
	input  logic [dac_pkg::pwl_word_width-1:0] data,
	input  logic step,
	output logic [dac_pkg::batch_width-1:0] batch,
	output logic ready
);

	logic [dac_pkg::pwl_word_width-1:0] mem [dac_pkg::pwl_depth];

	logic [dac_pkg::pwl_count_width-1:0] count;
	logic reload; // next write starts a new table at slot 0.
	logic [dac_pkg::pwl_addr_width-1:0] seg;
	logic [7:0] pos;
	logic [dac_pkg::sample_width-1:0] acc;

	logic [dac_pkg::pwl_addr_width-1:0] seg_next;
	logic [7:0] pos_next;
	logic [dac_pkg::sample_width-1:0] acc_next;

	assign ready = (count != '0);

	// walk four samples forward, crossing segment ends as needed.
	always_comb begin
		logic [dac_pkg::pwl_addr_width-1:0] s;
		logic [7:0] p;
		logic [dac_pkg::sample_width-1:0] a;
		logic [dac_pkg::pwl_word_width-1:0] w;
		s = seg;
		p = pos;
		a = acc;
		for (int i = 0; i < dac_pkg::batch_samples; i++) begin
			batch[i*dac_pkg::sample_width +: dac_pkg::sample_width] = a;
			w = mem[s];
			if (p + 8'd1 == w[7:0]) begin
				s = ({1'b0, s} + 1'b1 == count) ? '0 : s + 1'b1; // wrap after the last one.
				p = '0;
				a = mem[s][31:16];
			end else begin
				p = p + 8'd1;
				a = a + {{8{w[15]}}, w[15:8]}; // signed slope.
			end
		end
		seg_next = s;
		pos_next = p;
		acc_next = a;
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			mem[reload ? '0 : count[dac_pkg::pwl_addr_width-1:0]] <= data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			count  <= '0;
			reload <= 1'b0;
			seg    <= '0;
			pos    <= '0;
			acc    <= '0;
		end else if (clear) begin
			reload <= 1'b1;
			seg    <= '0;
			pos    <= '0;
			acc    <= mem[0][31:16];
		end else if (wr) begin
			reload <= 1'b0;
			count  <= reload ? dac_pkg::pwl_count_width'(1) : count + 1'b1;
			if (reload) acc <= data[31:16]; // playback opens on the first segment.
		end else if (step) begin
			seg <= seg_next;
			pos <= pos_next;
			acc <= acc_next;
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		(wr && !reload) |-> (count < dac_pkg::pwl_count_width'(dac_pkg::pwl_depth)));

endmodule

// ==== src/dac_batch_select.sv ====
`timescale 1ns/1ps

module dac_batch_select (
	input  logic clk,
	input  logic rst,
	input  logic [1:0] mode,
	input  logic halt,
	input  logic dac_rdy,
	input  logic [dac_pkg::batch_width-1:0] rand_batch,
	input  logic [dac_pkg::batch_width-1:0] tri_batch,
	input  logic [dac_pkg::batch_width-1:0] pwl_batch,
	input  logic pwl_ready,
	output logic [dac_pkg::batch_width-1:0] dac_batch,
	output logic dac_batch_valid,
	output logic step_rand,
	output logic step_tri,
	output logic step_pwl,
	output logic [1:0] dac_valid_edge
);

	logic mode_live;
	logic valid_q;
	logic [dac_pkg::batch_width-1:0] sel_batch;

	always_comb begin
		case (mode)
			dac_pkg::mode_rand: sel_batch = rand_batch;
			dac_pkg::mode_tri:  sel_batch = tri_batch;
			dac_pkg::mode_pwl:  sel_batch = pwl_batch;
			default:            sel_batch = '0;
		endcase
	end

	// pwl counts as live only once segments are stored.
	assign mode_live = (mode == dac_pkg::mode_rand) || (mode == dac_pkg::mode_tri) ||
		((mode == dac_pkg::mode_pwl) && pwl_ready);

	assign dac_batch_valid = mode_live && !halt && dac_rdy;
	assign dac_batch       = dac_batch_valid ? sel_batch : '0;

	// a transfer advances only the active generator.
	assign step_rand = dac_batch_valid && (mode == dac_pkg::mode_rand);
	assign step_tri  = dac_batch_valid && (mode == dac_pkg::mode_tri);
	assign step_pwl  = dac_batch_valid && (mode == dac_pkg::mode_pwl);

	always_ff @(posedge clk) begin
		if (rst) valid_q <= 1'b0;
		else     valid_q <= dac_batch_valid;
	end

	assign dac_valid_edge[0] = dac_batch_valid && !valid_q; // rising.
	assign dac_valid_edge[1] = !dac_batch_valid && valid_q; // falling.

	// halt leaves no mode behind one edge later.
	a_halt_clears: assert property (@(posedge clk) disable iff (rst)
		halt |=> (mode == dac_pkg::mode_none));

endmodule

// ==== src/dac_interface.sv ====
`timescale 1ns/1ps

module dac_interface (
	input  logic clk,
	input  logic rst,
	input  logic [dac_pkg::mem_size-1:0] fresh_bits,
	input  logic [dac_pkg::mem_size-1:0][dac_pkg::word_width-1:0] read_resps,
	input  logic halt,
	input  logic dac_rdy,
	input  logic [dac_pkg::pwl_word_width-1:0] pwl_data,
	input  logic pwl_valid,
	input  logic pwl_last,
	output logic [dac_pkg::batch_width-1:0] dac_batch,
	output logic dac_batch_valid,
	output logic [1:0] dac_valid_edge
);

	logic [1:0] mode;
	logic seed_load;
	logic [dac_pkg::batch_width-1:0] seeds;
	logic tri_restart;
	logic pwl_clear;
	logic pwl_wr;
	logic pwl_ready;
	logic step_rand;
	logic step_tri;
	logic step_pwl;
	logic [dac_pkg::batch_width-1:0] rand_batch;
	logic [dac_pkg::batch_width-1:0] tri_batch;
	logic [dac_pkg::batch_width-1:0] pwl_batch;

	dac_mode_decode u_decode (
		.clk(clk), .rst(rst),
		.fresh_bits(fresh_bits), .read_resps(read_resps), .halt(halt),
		.pwl_valid(pwl_valid), .pwl_last(pwl_last),
		.mode(mode), .seed_load(seed_load), .seeds(seeds),
		.tri_restart(tri_restart), .pwl_clear(pwl_clear), .pwl_wr(pwl_wr)
	);

	lfsr_bank u_lfsr (
		.clk(clk), .rst(rst),
		.seed_load(seed_load), .seeds(seeds), .step(step_rand),
		.batch(rand_batch)
	);

	tri_wave_gen u_tri (
		.clk(clk), .rst(rst),
		.restart(tri_restart), .step(step_tri),
		.batch(tri_batch)
	);

	pwl_gen u_pwl (
		.clk(clk), .rst(rst),
		.clear(pwl_clear), .wr(pwl_wr), .data(pwl_data), .step(step_pwl),
		.batch(pwl_batch), .ready(pwl_ready)
	);

	dac_batch_select u_select (
		.clk(clk), .rst(rst),
		.mode(mode), .halt(halt), .dac_rdy(dac_rdy),
		.rand_batch(rand_batch), .tri_batch(tri_batch), .pwl_batch(pwl_batch),
		.pwl_ready(pwl_ready),
		.dac_batch(dac_batch), .dac_batch_valid(dac_batch_valid),
		.step_rand(step_rand), .step_tri(step_tri), .step_pwl(step_pwl),
		.dac_valid_edge(dac_valid_edge)
	);

endmodule

// ==== dv/dac_tb.sv ====
`timescale 1ns/1ps

module dac_tb;

	logic clk;
	logic rst;
	logic [dac_pkg::mem_size-1:0] fresh_bits;
	logic [dac_pkg::mem_size-1:0][dac_pkg::word_width-1:0] read_resps;
	logic halt;
	logic dac_rdy;
	logic [dac_pkg::pwl_word_width-1:0] pwl_data;
	logic pwl_valid;
	logic pwl_last;
	logic [dac_pkg::batch_width-1:0] dac_batch;
	logic dac_batch_valid;
	logic [1:0] dac_valid_edge;

	// model of the active generator, advanced only on transfers.
	logic [1:0] model_mode;
	logic [dac_pkg::sample_width-1:0] lfsr_m [dac_pkg::batch_samples];
	int tri_n;
	int pwl_seg;
	int pwl_pos;
	int seg_count;
	logic [dac_pkg::pwl_word_width-1:0] segs [3];

	int errors;
	int xfers;
	int rises;
	int falls;
	bit timed_out;
	logic prev_valid;
	logic exp_valid;
	logic [1:0] exp_edge;
	logic [dac_pkg::batch_width-1:0] exp_batch;
	int unsigned seed_dummy;

	dac_interface u_dut (
		.clk(clk), .rst(rst),
		.fresh_bits(fresh_bits), .read_resps(read_resps), .halt(halt),
		.dac_rdy(dac_rdy), .pwl_data(pwl_data), .pwl_valid(pwl_valid), .pwl_last(pwl_last),
		.dac_batch(dac_batch), .dac_batch_valid(dac_batch_valid),
		.dac_valid_edge(dac_valid_edge)
	);

	always #5 clk = ~clk;

	// ready about 3 cycles in 4.
	task automatic drive_ready();
		forever begin
			@(posedge clk);
			dac_rdy <= ($urandom % 4) != 0;
		end
	endtask

	function automatic logic [15:0] lfsr_next(logic [15:0] s);
		if (s[0]) return (s >> 1) ^ dac_pkg::lfsr_taps;
		return s >> 1;
	endfunction

	function automatic logic [15:0] tri_sample(int idx);
		int phase;
		phase = (idx * dac_pkg::tri_step) % (2 * dac_pkg::tri_peak);
		if (phase > dac_pkg::tri_peak) phase = 2 * dac_pkg::tri_peak - phase; // fold down.
		return 16'(phase);
	endfunction

	function automatic bit model_live();
		if (model_mode == dac_pkg::mode_none) return 0;
		if (model_mode == dac_pkg::mode_pwl) return seg_count != 0;
		return 1;
	endfunction

	// expected batch of the current model state, sample 0 low.
	function automatic logic [63:0] ref_batch();
		logic [63:0] b;
		logic [31:0] w;
		int s;
		int p;
		b = '0;
		s = pwl_seg;
		p = pwl_pos;
		for (int i = 0; i < dac_pkg::batch_samples; i++) begin
			case (model_mode)
				dac_pkg::mode_rand: b[i*16 +: 16] = lfsr_m[i];
				dac_pkg::mode_tri:  b[i*16 +: 16] = tri_sample(tri_n + i);
				dac_pkg::mode_pwl: begin
					w = segs[s];
					b[i*16 +: 16] = w[31:16] + 16'($signed(w[15:8]) * p); // start plus slope times pos.
					p++;
					if (p == w[7:0]) begin
						p = 0;
						s = (s + 1) % seg_count;
					end
				end
				default: b[i*16 +: 16] = '0;
			endcase
		end
		return b;
	endfunction

	task automatic advance_model();
		logic [31:0] w;
		for (int i = 0; i < dac_pkg::batch_samples; i++) begin
			case (model_mode)
				dac_pkg::mode_rand: lfsr_m[i] = lfsr_next(lfsr_m[i]);
				dac_pkg::mode_tri:  tri_n++;
				dac_pkg::mode_pwl: begin
					w = segs[pwl_seg];
					pwl_pos++;
					if (pwl_pos == w[7:0]) begin
						pwl_pos = 0;
						pwl_seg = (pwl_seg + 1) % seg_count;
					end
				end
				default: ;
			endcase
		end
	endtask

	// mid-cycle check of every output against the model.
	always @(negedge clk) begin
		if (rst) begin
			prev_valid = 1'b0;
		end else begin
			exp_valid = model_live() && !halt && dac_rdy;
			if (dac_batch_valid !== exp_valid) begin
				errors++;
				$display("error at %0d ns: valid is %b, expected %b", $time, dac_batch_valid,
					exp_valid);
			end
			exp_edge = {prev_valid & ~dac_batch_valid, dac_batch_valid & ~prev_valid};
			if (dac_valid_edge !== exp_edge) begin
				errors++;
				$display("error at %0d ns: valid edge is %b after valid %b then %b", $time,
					dac_valid_edge, prev_valid, dac_batch_valid);
			end
			if (dac_valid_edge[0]) rises++;
			if (dac_valid_edge[1]) falls++;
			if (dac_batch_valid) begin
				exp_batch = ref_batch();
				if (dac_batch !== exp_batch) begin
					errors++;
					$display("error at %0d ns: batch %h, expected %h", $time, dac_batch, exp_batch);
				end
				advance_model();
				xfers++;
			end else if (dac_batch !== '0) begin
				errors++;
				$display("error at %0d ns: batch %h while not valid", $time, dac_batch);
			end
			prev_valid = dac_batch_valid;
		end
	end

	task automatic wait_transfers(input int n);
		int target;
		int cycles;
		target = xfers + n;
		cycles = 0;
		while (xfers < target && !timed_out) begin
			@(posedge clk);
			cycles++;
			if (cycles > 20 * n + 100) begin
				$display("timeout at %0d ns, %0d of %0d transfers seen", $time, xfers + n - target, n);
				timed_out = 1;
			end
		end
	endtask

	// one-cycle fresh pulse, returns at the edge that samples it.
	task automatic pulse_fresh(input logic [dac_pkg::mem_size-1:0] bits);
		fresh_bits <= bits;
		@(posedge clk);
		fresh_bits <= '0;
	endtask

	task automatic start_random(input logic [63:0] s, input bit with_tri);
		logic [dac_pkg::mem_size-1:0] bits;
		bits = '0;
		bits[dac_pkg::seed_valid_id] = 1'b1;
		bits[dac_pkg::tri_wave_id] = with_tri;
		for (int i = 0; i < 4; i++) begin
			read_resps[dac_pkg::seed_base_id + i] <= {16'hA5A5, s[i*16 +: 16]}; // upper half ignored.
		end
		pulse_fresh(bits);
		model_mode = dac_pkg::mode_none;
		@(posedge clk); // lfsrs load here.
		for (int i = 0; i < 4; i++) lfsr_m[i] = s[i*16 +: 16];
		model_mode = dac_pkg::mode_rand;
	endtask

	task automatic load_pwl();
		pulse_fresh(16'(1) << dac_pkg::pwl_prep_id);
		model_mode = dac_pkg::mode_none;
		for (int k = 0; k < 3; k++) begin
			pwl_valid <= 1'b1;
			pwl_data  <= segs[k];
			pwl_last  <= (k == 2);
			@(posedge clk);
		end
		pwl_valid <= 1'b0;
		pwl_last  <= 1'b0;
		seg_count = 3;
		pwl_seg = 0;
		pwl_pos = 0;
		model_mode = dac_pkg::mode_pwl;
	endtask

	initial begin
		seed_dummy = $urandom(5288);
		clk = 1'b0;
		rst = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		halt = 1'b0;
		dac_rdy = 1'b0;
		pwl_data = '0;
		pwl_valid = 1'b0;
		pwl_last = 1'b0;
		model_mode = dac_pkg::mode_none;
		tri_n = 0;
		pwl_seg = 0;
		pwl_pos = 0;
		seg_count = 0;
		segs[0] = {16'h1000, 8'h05, 8'd6};
		segs[1] = {16'h8000, 8'hFD, 8'd3}; // falling slope.
		segs[2] = {16'hFFF0, 8'h07, 8'd5}; // wraps through zero.
		fork
			drive_ready();
		join_none
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		repeat (20) @(posedge clk); // idle, nothing may be valid.
		start_random({16'h1234, 16'hBEEF, 16'h0001, 16'hACE1}, 0);
		wait_transfers(30);

		pulse_fresh(16'(1) << dac_pkg::tri_wave_id);
		model_mode = dac_pkg::mode_tri;
		tri_n = 0;
		wait_transfers(40); // more than one full period.

		load_pwl();
		wait_transfers(12);
		pulse_fresh(16'(1) << dac_pkg::run_pwl_id);
		model_mode = dac_pkg::mode_pwl;
		pwl_seg = 0;
		pwl_pos = 0;
		wait_transfers(8);

		halt <= 1'b1;
		@(posedge clk);
		model_mode = dac_pkg::mode_none;
		repeat (3) @(posedge clk);
		halt <= 1'b0;
		repeat (10) @(posedge clk);

		start_random({$urandom, $urandom}, 1); // seed wins over triangle.
		wait_transfers(10);
		repeat (2) @(posedge clk);

		if (rises == 0 || falls == 0) begin
			errors++;
			$display("error at %0d ns: no valid edges seen, %0d rising %0d falling", $time,
				rises, falls);
		end
		$display("transfers %0d, errors %0d, timeouts %0d", xfers, errors, timed_out);
		if (errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== all.f ====
src/dac_pkg.sv
src/dac_mode_decode.sv
src/lfsr_bank.sv
src/tri_wave_gen.sv
src/pwl_gen.sv
src/dac_batch_select.sv
src/dac_interface.sv
dv/dac_tb.sv

// ==== Bender.yml ====
package:
  name: dac_interface

sources:
  - src/dac_pkg.sv
  - src/dac_mode_decode.sv
  - src/lfsr_bank.sv
  - src/tri_wave_gen.sv
  - src/pwl_gen.sv
  - src/dac_batch_select.sv
  - src/dac_interface.sv
  - target: test
    files:
      - dv/dac_tb.sv
